/* all.f */
source/trigger_pkg.sv
source/sample_stream_if.sv
source/trigger_config_regs.sv
source/baseline_formatter.sv
source/pretrigger_delay.sv
source/edge_trigger.sv
source/event_framer.sv
source/data_trigger_top.sv
test/tb_data_trigger.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench, then decide the result from the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_data_trigger -o tb_sim > build.log 2>&1 &&
./obj_dir/tb_sim > sim.log 2>&1 ||
{ echo "build or run error, see build.log and sim.log"; exit 1; }

grep -q "sim failed" sim.log &&
{ echo "simulation reported failure, see sim.log"; exit 1; } ||
{ echo "simulation clean"; exit 0; }

/* source/baseline_formatter.sv */
`timescale 1ns/1ps

module baseline_formatter import trigger_pkg::*; (
    input  logic                         ACLK,
    input  logic                         ARESET,
    input  logic [data_width-1:0]        h_tdata,
    input  logic                         h_tvalid,
    input  logic [l_data_width-1:0]      l_tdata,
    input  logic                         l_tvalid,
    input  logic [timestamp_width-1:0]   timestamp,
    input  trigger_cfg_t                 cfg,
    sample_stream_if.source              out_bus,
    output logic signed [adc_bits:0]     h_sub0,
    output logic signed [adc_bits:0]     h_sub1
);

    logic signed [adc_bits-1:0]     raw [h_samples];
    logic signed [adc_bits:0]       sub [h_samples];
    logic [h_samples-1:0]           sat_hit;
    logic [data_width-1:0]          normal_word;
    logic signed [adc_bits+1:0]     sub_sum;
    logic signed [adc_bits+1:0]     sub_half;
    logic signed [sample_width-1:0] l_sub;
    logic [data_width-1:0]          combined_word;

    always_comb begin
        for (int i = 0; i < h_samples; i++) begin
            // adc data sits in the low bits of each slot
            raw[i] = h_tdata[i*sample_width +: adc_bits];
            sub[i] = raw[i] - $signed(cfg.h_baseline);
            normal_word[i*sample_width +: sample_width] =
                {{(sample_width-adc_bits-1){sub[i][adc_bits]}}, sub[i]};
            sat_hit[i] = (raw[i] >= $signed(cfg.sat_upper))
                      || (raw[i] <= $signed(cfg.sat_lower));
        end
    end

    // average of the two high-gain samples next to the low-gain sample
    assign sub_sum  = sub[0] + sub[1];
    assign sub_half = sub_sum >>> 1;
    assign l_sub    = $signed(l_tdata) - $signed(cfg.l_baseline);
    assign combined_word = {{(sample_width-adc_bits-2){sub_half[adc_bits+1]}}, sub_half, l_sub};

    // the trigger needs these in the input cycle to open the pre-window in time
    assign h_sub0 = sub[0];
    assign h_sub1 = sub[1];

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            out_bus.valid <= 1'b0;
        end else begin
            out_bus.valid <= h_tvalid && l_tvalid;
        end
    end

    always_ff @(posedge ACLK) begin
        out_bus.normal_data   <= normal_word;
        out_bus.combined_data <= combined_word;
        out_bus.saturated     <= |sat_hit;
        out_bus.timestamp     <= timestamp;
    end

endmodule

/* source/data_trigger_top.sv */
`timescale 1ns/1ps

module data_trigger_top import trigger_pkg::*; #(
    parameter int MAX_PRE  = 8,
    parameter int MAX_POST = 8
) (
    input  logic                           ACLK,
    input  logic                           ARESET,
    input  logic                           set_config,
    input  logic                           acquire_mode,
    input  logic [len_width-1:0]           pre_len,
    input  logic [len_width-1:0]           post_len,
    input  logic signed [sample_width-1:0] rising_thr,
    input  logic signed [sample_width-1:0] falling_thr,
    input  logic signed [adc_bits:0]       h_baseline,
    input  logic signed [sample_width-1:0] l_baseline,
    input  logic signed [sample_width-1:0] sat_upper,
    input  logic signed [sample_width-1:0] sat_lower,
    input  logic [data_width-1:0]          h_tdata,
    input  logic                           h_tvalid,
    input  logic [l_data_width-1:0]        l_tdata,
    input  logic                           l_tvalid,
    input  logic [timestamp_width-1:0]     timestamp,
    output logic [out_width-1:0]           m_tdata,
    output logic                           m_tvalid,
    output logic [data_width-1:0]          h_gain_tdata
);

    trigger_cfg_t             cfg_in;
    trigger_cfg_t             cfg;
    logic signed [adc_bits:0] h_sub0;
    logic signed [adc_bits:0] h_sub1;
    logic                     gate;

    sample_stream_if fmt_bus ();
    sample_stream_if dly_bus ();

    always_comb begin
        cfg_in.acquire_mode = acquire_mode;
        cfg_in.pre_len      = pre_len;
        cfg_in.post_len     = post_len;
        cfg_in.rising_thr   = rising_thr;
        cfg_in.falling_thr  = falling_thr;
        cfg_in.h_baseline   = h_baseline;
        cfg_in.l_baseline   = l_baseline;
        cfg_in.sat_upper    = sat_upper[adc_bits-1:0];
        cfg_in.sat_lower    = sat_lower[adc_bits-1:0];
    end

    trigger_config_regs #(.MAX_PRE(MAX_PRE), .MAX_POST(MAX_POST)) i_config (
        .ACLK(ACLK), .ARESET(ARESET), .set_config(set_config), .cfg_in(cfg_in), .cfg(cfg)
    );

    baseline_formatter i_formatter (
        .ACLK(ACLK), .ARESET(ARESET),
        .h_tdata(h_tdata), .h_tvalid(h_tvalid), .l_tdata(l_tdata), .l_tvalid(l_tvalid),
        .timestamp(timestamp), .cfg(cfg), .out_bus(fmt_bus.source),
        .h_sub0(h_sub0), .h_sub1(h_sub1)
    );

    pretrigger_delay #(.MAX_PRE(MAX_PRE)) i_delay (
        .ACLK(ACLK), .cfg(cfg), .in_bus(fmt_bus.sink), .out_bus(dly_bus.source)
    );

    // beat validity needs both gain streams
    edge_trigger #(.MAX_PRE(MAX_PRE), .MAX_POST(MAX_POST)) i_trigger (
        .ACLK(ACLK), .ARESET(ARESET), .set_config(set_config), .cfg(cfg),
        .h_sub0(h_sub0), .h_sub1(h_sub1), .beat_valid(h_tvalid && l_tvalid), .gate(gate)
    );

    event_framer i_framer (
        .ACLK(ACLK), .ARESET(ARESET), .set_config(set_config), .cfg(cfg),
        .in_bus(dly_bus.sink), .gate(gate),
        .m_tdata(m_tdata), .m_tvalid(m_tvalid), .h_gain_tdata(h_gain_tdata)
    );

endmodule

/* source/edge_trigger.sv */
`timescale 1ns/1ps

module edge_trigger import trigger_pkg::*; #(
    parameter int MAX_PRE  = 8,
    parameter int MAX_POST = 8
) (
    input  logic                     ACLK,
    input  logic                     ARESET,
    input  logic                     set_config,
    input  trigger_cfg_t             cfg,
    input  logic signed [adc_bits:0] h_sub0,
    input  logic signed [adc_bits:0] h_sub1,
    input  logic                     beat_valid,
    output logic                     gate
);

    localparam int win_width   = $clog2(MAX_PRE + MAX_POST + 2);
    localparam int quiet_width = $clog2(MAX_PRE + 2);

    trig_state_t                    state_q;
    trig_state_t                    state_d;
    logic signed [sample_width-1:0] rising_thr;
    logic signed [sample_width-1:0] falling_thr;
    logic                           above;
    logic                           below;
    logic                           hit;
    logic                           restart_q;
    logic [quiet_width-1:0]         quiet_cnt;
    logic                           quiet_hold;
    logic                           quiet;
    logic [win_width-1:0]           win_cnt;
    logic [win_width-1:0]           win_reload;

    assign rising_thr  = cfg.rising_thr;
    assign falling_thr = cfg.falling_thr;

    assign above = (h_sub0 > rising_thr) || (h_sub1 > rising_thr);
    assign below = (h_sub0 < falling_thr) && (h_sub1 < falling_thr);

    // hysteresis, invalid beats leave the state alone
    always_comb begin
        state_d = state_q;
        if (beat_valid) begin
            case (state_q)
                idle:   if (above) state_d = active;
                active: if (below) state_d = idle;
            endcase
        end
    end

    assign hit = beat_valid && (state_d == active);

    // quiet period covers the restart cycle plus pre_len + 2 more
    assign quiet_hold = restart_q || (quiet_cnt != '0);
    assign quiet      = ARESET || set_config || quiet_hold;

    always_ff @(posedge ACLK) begin
        if (ARESET || set_config) begin
            restart_q <= 1'b1;
            quiet_cnt <= '0;
        end else begin
            restart_q <= 1'b0;
            if (restart_q) begin
                // new pre_len is visible from this cycle on
                quiet_cnt <= quiet_width'(cfg.pre_len) + quiet_width'(1);
            end else if (quiet_cnt != '0) begin
                quiet_cnt <= quiet_cnt - 1'b1;
            end
        end
    end

    // the hit for beat m is known while beat m - pre_len sits on the delay output,
    // so a count of pre_len + post_len + 1 spans the whole window
    assign win_reload = win_width'(cfg.pre_len) + win_width'(cfg.post_len) + win_width'(1);

    always_ff @(posedge ACLK) begin
        if (quiet) begin
            state_q <= idle;
            win_cnt <= '0;
        end else begin
            state_q <= state_d;
            if (hit) begin
                win_cnt <= win_reload;
            end else if (win_cnt != '0) begin
                win_cnt <= win_cnt - 1'b1;
            end
        end
    end

    assign gate = (win_cnt != '0);

    a_gate_quiet : assert property (@(posedge ACLK) quiet_hold |-> !gate)
        else $error("gate open during quiet period");

endmodule

/* source/event_framer.sv */
`timescale 1ns/1ps

module event_framer import trigger_pkg::*; (
    input  logic                  ACLK,
    input  logic                  ARESET,
    input  logic                  set_config,
    input  trigger_cfg_t          cfg,
    sample_stream_if.sink         in_bus,
    input  logic                  gate,
    output logic [out_width-1:0]  m_tdata,
    output logic                  m_tvalid,
    output logic [data_width-1:0] h_gain_tdata
);

    logic                      use_combined;
    logic [data_width-1:0]     sel_data;
    logic [info_width-1:0]     info;
    logic [trig_cfg_width-1:0] trig_field;

    // saturated beats fall back to the low-gain channel
    assign use_combined = in_bus.saturated || cfg.acquire_mode;
    assign sel_data     = use_combined ? in_bus.combined_data : in_bus.normal_data;
    assign trig_field   = {cfg.rising_thr, cfg.falling_thr};

    always_comb begin
        info = '0;
        info[normal_info_bit] = !use_combined;
    end

    always_ff @(posedge ACLK) begin
        if (ARESET || set_config) begin
            m_tdata      <= '1;
            m_tvalid     <= 1'b0;
            h_gain_tdata <= '1;
        end else begin
            m_tdata[data_field_lsb +: data_width]      <= sel_data;
            m_tdata[info_field_lsb +: info_width]      <= info;
            m_tdata[ts_field_lsb +: timestamp_width]   <= in_bus.timestamp;
            m_tdata[cfg_field_lsb +: trig_cfg_width]   <= trig_field;
            m_tvalid     <= in_bus.valid && gate;
            // charge integrator copy with the same timing as m_tdata
            h_gain_tdata <= in_bus.normal_data;
        end
    end

    // the cleared trigger window keeps the second cycle low as well
    a_quiet_after_restart : assert property (
        @(posedge ACLK) ($past(ARESET || set_config) || $past(ARESET || set_config, 2))
            |-> !m_tvalid)
        else $error("m_tvalid high within two cycles of reset or set_config");

endmodule

/* source/pretrigger_delay.sv */
`timescale 1ns/1ps

module pretrigger_delay import trigger_pkg::*; #(
    parameter int MAX_PRE = 8
) (
    input  logic            ACLK,
    input  trigger_cfg_t    cfg,
    sample_stream_if.sink   in_bus,
    sample_stream_if.source out_bus
);

    localparam int beat_width = 2 + 2 * data_width + timestamp_width;

    logic [beat_width-1:0] in_word;
    logic [beat_width-1:0] tap_word;
    // stage[k] holds the beat seen k cycles ago
    logic [beat_width-1:0] stage [1:MAX_PRE];

    assign in_word = {in_bus.valid,
                      in_bus.saturated,
                      in_bus.normal_data,
                      in_bus.combined_data,
                      in_bus.timestamp};

    always_ff @(posedge ACLK) begin
        stage[1] <= in_word;
        for (int i = 2; i <= MAX_PRE; i++) begin
            stage[i] <= stage[i-1];
        end
    end

    assign tap_word = stage[cfg.pre_len];

    assign {out_bus.valid,
            out_bus.saturated,
            out_bus.normal_data,
            out_bus.combined_data,
            out_bus.timestamp} = tap_word;

    // config comes from another block, so guard the tap here
    a_tap_in_range : assert property (@(posedge ACLK) cfg.pre_len <= MAX_PRE)
        else $error("delay tap %0d beyond %0d stages", cfg.pre_len, MAX_PRE);

endmodule

/* source/sample_stream_if.sv */
`timescale 1ns/1ps

// one formatted beat per clock, valid-only, no back-pressure
interface sample_stream_if import trigger_pkg::*; ();

    logic                       valid;
    logic [data_width-1:0]      normal_data;
    logic [data_width-1:0]      combined_data;
    logic                       saturated;
    logic [timestamp_width-1:0] timestamp;

    modport source (
        output valid,
        output normal_data,
        output combined_data,
        output saturated,
        output timestamp
    );

    modport sink (
        input valid,
        input normal_data,
        input combined_data,
        input saturated,
        input timestamp
    );

endinterface

/* source/trigger_config_regs.sv */
`timescale 1ns/1ps

module trigger_config_regs import trigger_pkg::*; #(
    parameter int MAX_PRE  = 8,
    parameter int MAX_POST = 8
) (
    input  logic         ACLK,
    input  logic         ARESET,
    input  logic         set_config,
    input  trigger_cfg_t cfg_in,
    output trigger_cfg_t cfg
);

    // the whole set changes at once, so downstream blocks never see a mix
    // of old and new fields
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            cfg <= cfg_default;
        end else if (set_config) begin
            cfg.acquire_mode <= cfg_in.acquire_mode;
            cfg.pre_len      <= cfg_in.pre_len;
            cfg.post_len     <= cfg_in.post_len;
            cfg.rising_thr   <= cfg_in.rising_thr;
            cfg.falling_thr  <= cfg_in.falling_thr;
            cfg.h_baseline   <= cfg_in.h_baseline;
            cfg.l_baseline   <= cfg_in.l_baseline;
            // saturation limits compare against raw 12 bit samples
            cfg.sat_upper    <= cfg_in.sat_upper[adc_bits-1:0];
            cfg.sat_lower    <= cfg_in.sat_lower[adc_bits-1:0];
        end
    end

    // lengths must fit the delay line and the window counter
    property p_len_in_range;
        @(posedge ACLK) disable iff (ARESET)
        set_config |=> (cfg.pre_len >= 1) && (cfg.pre_len <= MAX_PRE)
                       && (cfg.post_len <= MAX_POST);
    endproperty

    a_len_in_range : assert property (p_len_in_range)
        else $error("pre_len %0d or post_len %0d out of range", cfg.pre_len, cfg.post_len);

endmodule

/* source/trigger_pkg.sv */
package trigger_pkg;

    // sample slot and ADC geometry
    localparam int sample_width    = 16;
    localparam int adc_bits        = 12;
    localparam int h_samples       = 2;
    localparam int data_width      = h_samples * sample_width;
    localparam int l_data_width    = sample_width;
    localparam int timestamp_width = 32;
    localparam int len_width       = 4;

    // output word is data | info | timestamp | trigger config, msb first
    localparam int info_width      = 8;
    localparam int normal_info_bit = 4;
    localparam int trig_cfg_width  = 2 * sample_width;
    localparam int out_width       = data_width + info_width + timestamp_width + trig_cfg_width;
    localparam int cfg_field_lsb   = 0;
    localparam int ts_field_lsb    = cfg_field_lsb + trig_cfg_width;
    localparam int info_field_lsb  = ts_field_lsb + timestamp_width;
    localparam int data_field_lsb  = info_field_lsb + info_width;

    typedef enum logic {
        idle,
        active
    } trig_state_t;

    typedef struct packed {
        logic                          acquire_mode;
        logic [len_width-1:0]          pre_len;
        logic [len_width-1:0]          post_len;
        logic signed [sample_width-1:0] rising_thr;
        logic signed [sample_width-1:0] falling_thr;
        logic signed [adc_bits:0]      h_baseline;
        logic signed [sample_width-1:0] l_baseline;
        logic signed [adc_bits-1:0]    sat_upper;
        logic signed [adc_bits-1:0]    sat_lower;
    } trigger_cfg_t;

    localparam trigger_cfg_t cfg_default = '{
        acquire_mode: 1'b0,
        pre_len:      4'd1,
        post_len:     4'd1,
        rising_thr:   16'sd1024,
        falling_thr:  16'sd1024,
        h_baseline:   -13'sd1024,
        l_baseline:   16'sd128,
        sat_upper:    12'sd2047,
        sat_lower:    -12'sd2048
    };

endpackage

/* test/tb_data_trigger.sv */
`timescale 1ns/1ps

module tb_data_trigger import trigger_pkg::*; ();

    localparam int NB        = 20;
    localparam int IDLE_PRE  = 8;
    localparam int FLUSH     = 8;
    localparam int NROWS     = 5;
    localparam int ROW_CYC   = 1 + IDLE_PRE + NB + FLUSH;
    localparam int WD_CYCLES = NROWS * ROW_CYC * 4 + 100;
    localparam int HBASE     = 100;
    localparam int LBASE     = 50;
    localparam int SAT_LO    = -2048;
    localparam int HIT_VAL   = 900;

    typedef struct {
        string name;
        bit    mode;
        int    pre, post, rth, fth, sat_up;
        int    hit_at, hold, sat_at, gap_at;
        int    cfg_at, new_rth, new_fth, ign_at, hit2_at;
    } row_t;

    logic                    ACLK;
    logic                    ARESET;
    logic                    set_config;
    logic                    acquire_mode;
    logic [3:0]              pre_len;
    logic [3:0]              post_len;
    logic signed [15:0]      rising_thr;
    logic signed [15:0]      falling_thr;
    logic signed [12:0]      h_baseline;
    logic signed [15:0]      l_baseline;
    logic signed [15:0]      sat_upper;
    logic signed [15:0]      sat_lower;
    logic [31:0]             h_tdata;
    logic                    h_tvalid;
    logic [15:0]             l_tdata;
    logic                    l_tvalid;
    logic [31:0]             timestamp;
    logic [out_width-1:0]    m_tdata;
    logic                    m_tvalid;
    logic [31:0]             h_gain_tdata;

    row_t                    rows [NROWS];
    logic [out_width-1:0]    got_q [$];
    logic [31:0]             got_h_q [$];
    int                      ts_next;
    int                      value_errs;
    int                      missing_errs;
    int                      extra_errs;

    data_trigger_top #(.MAX_PRE(8), .MAX_POST(8)) i_dut (.*);

    initial ACLK = 1'b0;
    always #50 ACLK = ~ACLK;

    // every valid output beat is kept, the row check sorts them out
    always @(posedge ACLK) begin
        if (m_tvalid) begin
            got_q.push_back(m_tdata);
            got_h_q.push_back(h_gain_tdata);
        end
    end

    initial begin
        #(WD_CYCLES * 100);
        $display("watchdog expired after %0d cycles, run did not finish", WD_CYCLES);
        $display("sim failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [out_width-1:0] exp,
                               input logic [out_width-1:0] act);
        if (exp !== act) begin
            value_errs++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic drive_cycle(input bit hv, input bit lv, input int r0, input int r1,
                               input int lr, input bit strobe);
        @(posedge ACLK);
        h_tvalid   <= hv;
        l_tvalid   <= lv;
        h_tdata    <= {4'h0, r1[11:0], 4'h0, r0[11:0]};
        l_tdata    <= lr[15:0];
        set_config <= strobe;
        timestamp  <= ts_next;
        ts_next++;
    endtask

    // same time step as the set_config cycle
    task automatic apply_cfg(input bit mode, input int pre, input int post, input int rth,
                             input int fth, input int sat);
        acquire_mode <= mode;
        pre_len      <= 4'(pre);
        post_len     <= 4'(post);
        rising_thr   <= 16'(rth);
        falling_thr  <= 16'(fth);
        h_baseline   <= 13'(HBASE);
        l_baseline   <= 16'(LBASE);
        sat_upper    <= 16'(sat);
        sat_lower    <= 16'(SAT_LO);
    endtask

    function automatic logic [out_width-1:0] expect_word(input int s0, input int s1,
            input int lr, input bit comb, input int ts, input int rth, input int fth);
        logic [31:0] d;
        logic [15:0] l16;
        int          avg;
        avg = (s0 + s1) >>> 1;
        l16 = 16'(lr - LBASE);
        d   = comb ? {avg[15:0], l16} : {s1[15:0], s0[15:0]};
        return {d, comb ? 8'h00 : 8'h10, 32'(ts), rth[15:0], fth[15:0]};
    endfunction

    task automatic run_row(input row_t r);
        int                   raw0 [NB];
        int                   raw1 [NB];
        int                   lraw [NB];
        int                   rth_n [NB];
        int                   fth_n [NB];
        bit                   vld [NB];
        bit                   hit [NB];
        int                   s0, s1, base, i, j;
        bit                   st, quiet, in_win, comb;
        logic [out_width-1:0] exp_q [$];
        logic [31:0]          exp_h [$];
        logic [out_width-1:0] w;
        base = ts_next + 1 + IDLE_PRE;
        // quiet-level samples stay below every threshold in the table
        for (int n = 0; n < NB; n++) begin
            raw0[n] = int'($urandom % 400) - 200 + HBASE;
            raw1[n] = int'($urandom % 400) - 200 + HBASE;
            lraw[n] = int'($urandom & 32'hffff);
            if (n == r.hit_at || n == r.hit2_at || n == r.ign_at)
                raw0[n] = HIT_VAL + HBASE;
            else if (n > r.hit_at && n <= r.hit_at + r.hold)
                raw0[n] = (r.rth + r.fth) / 2 + HBASE;
            if (n == r.sat_at)
                raw1[n] = r.sat_up;
            vld[n] = (n != r.gap_at);
        end
        // hysteresis model with the quiet period after a mid-row reload
        st = 1'b0;
        for (int n = 0; n < NB; n++) begin
            quiet    = r.cfg_at >= 0 && n >= r.cfg_at && n <= r.cfg_at + r.pre + 2;
            rth_n[n] = (r.cfg_at >= 0 && n > r.cfg_at) ? r.new_rth : r.rth;
            fth_n[n] = (r.cfg_at >= 0 && n > r.cfg_at) ? r.new_fth : r.fth;
            s0 = raw0[n] - HBASE;
            s1 = raw1[n] - HBASE;
            if (quiet)
                st = 1'b0;
            else if (vld[n] && !st && (s0 > rth_n[n] || s1 > rth_n[n]))
                st = 1'b1;
            else if (vld[n] && st && s0 < fth_n[n] && s1 < fth_n[n])
                st = 1'b0;
            hit[n] = !quiet && vld[n] && st;
        end
        for (int n = 0; n < NB; n++) begin
            in_win = 1'b0;
            for (int m = 0; m < NB; m++) begin
                // an old window is cut where set_config resets the output
                if (hit[m] && m >= n - r.post && m <= n + r.pre &&
                    (r.cfg_at < 0 || m > r.cfg_at || n + r.pre + 1 < r.cfg_at))
                    in_win = 1'b1;
            end
            if (vld[n] && in_win) begin
                comb = r.mode || raw0[n] >= r.sat_up || raw1[n] >= r.sat_up
                    || raw0[n] <= SAT_LO || raw1[n] <= SAT_LO;
                s0 = raw0[n] - HBASE;
                s1 = raw1[n] - HBASE;
                exp_q.push_back(expect_word(s0, s1, lraw[n], comb, base + n,
                                            rth_n[n], fth_n[n]));
                w = expect_word(s0, s1, lraw[n], 1'b0, 0, 0, 0);
                exp_h.push_back(w[out_width-1 -: 32]);
            end
        end
        drive_cycle(1'b0, 1'b0, 0, 0, 0, 1'b1);
        apply_cfg(r.mode, r.pre, r.post, r.rth, r.fth, r.sat_up);
        repeat (IDLE_PRE) drive_cycle(1'b0, 1'b0, 0, 0, 0, 1'b0);
        for (int n = 0; n < NB; n++) begin
            // a gap beat drops only the low-gain valid
            drive_cycle(1'b1, vld[n], raw0[n], raw1[n], lraw[n], n == r.cfg_at);
            if (n == r.cfg_at)
                apply_cfg(r.mode, r.pre, r.post, r.new_rth, r.new_fth, r.sat_up);
        end
        repeat (FLUSH) drive_cycle(1'b0, 1'b0, 0, 0, 0, 1'b0);
        i = 0;
        j = 0;
        while (i < exp_q.size() || j < got_q.size()) begin
            if (j >= got_q.size() || (i < exp_q.size() &&
                exp_q[i][ts_field_lsb +: 32] < got_q[j][ts_field_lsb +: 32])) begin
                missing_errs++;
                $display("%s: beat with timestamp %0d was expected but never emitted",
                         r.name, exp_q[i][ts_field_lsb +: 32]);
                i++;
            end else if (i >= exp_q.size() ||
                got_q[j][ts_field_lsb +: 32] < exp_q[i][ts_field_lsb +: 32]) begin
                extra_errs++;
                $display("%s: unexpected beat emitted with timestamp %0d",
                         r.name, got_q[j][ts_field_lsb +: 32]);
                j++;
            end else begin
                check_value(r.name, exp_q[i], got_q[j]);
                check_value({r.name, "_h_gain"}, out_width'(exp_h[i]), out_width'(got_h_q[j]));
                i++;
                j++;
            end
        end
        got_q.delete();
        got_h_q.delete();
    endtask

    initial begin
        void'($urandom(32'h03ab_fd96));
        ARESET     = 1'b1;
        set_config = 1'b0;
        h_tdata    = '0;
        h_tvalid   = 1'b0;
        l_tdata    = '0;
        l_tvalid   = 1'b0;
        timestamp  = '0;
        ts_next    = 0;
        apply_cfg(1'b0, 1, 1, 1024, 1024, 2047);
        value_errs   = 0;
        missing_errs = 0;
        extra_errs   = 0;
        // name mode pre post rth fth sat_up hit hold sat gap cfg new_rth new_fth ign hit2
        rows[0] = '{"normal", 1'b0, 2, 3, 500, 500, 2047, 4, 0, -1, -1, -1, 0, 0, -1, -1};
        rows[1] = '{"hysteresis", 1'b0, 1, 2, 600, 200, 2047, 3, 4, -1, -1, -1, 0, 0, -1, -1};
        rows[2] = '{"saturation", 1'b0, 2, 1, 500, 500, 1900, 4, 0, 4, -1, -1, 0, 0, -1, -1};
        rows[3] = '{"acquire", 1'b1, 3, 3, 500, 500, 2047, 5, 0, -1, 6, -1, 0, 0, -1, -1};
        rows[4] = '{"reconfig", 1'b0, 2, 2, 500, 500, 2047, 3, 0, -1, -1, 6, 700, 700, 7, 14};
        @(posedge ACLK);
        @(posedge ACLK);
        // outputs already reset by the first edge
        check_value("reset_valid", '0, out_width'(m_tvalid));
        check_value("reset_tdata", '1, m_tdata);
        check_value("reset_h_gain", out_width'(32'hffff_ffff), out_width'(h_gain_tdata));
        ARESET <= 1'b0;
        for (int k = 0; k < NROWS; k++) begin
            run_row(rows[k]);
        end
        $display("errors: value %0d, missing %0d, extra %0d",
                 value_errs, missing_errs, extra_errs);
        if (value_errs + missing_errs + extra_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
